// File: hw/softex_defs.svh
// Register map, command bit positions and sizing constants of the softmax sequencing core
// Include this wherever an offset, a command bit or a width is needed
`ifndef SOFTEX_DEFS_SVH
`define SOFTEX_DEFS_SVH

`define SOFTEX_REG_CTRL       12'h000
`define SOFTEX_REG_STATUS     12'h004
`define SOFTEX_REG_IN_ADDR    12'h008
`define SOFTEX_REG_OUT_ADDR   12'h00C
`define SOFTEX_REG_TOT_LEN    12'h010
`define SOFTEX_REG_COMMANDS   12'h014

`define SOFTEX_CMD_ACC_ONLY   0
`define SOFTEX_CMD_DIV_ONLY   1
`define SOFTEX_CMD_LAST       2
`define SOFTEX_CMD_ACQUIRE    3

`define SOFTEX_BEAT_BYTES     16
`define SOFTEX_N_SLOTS        4
`define SOFTEX_FP_W           32

`endif

// File: hw/softex_pkg.sv
// Shared types of the softmax sequencing core: controller states, decoded command and slot entry
`default_nettype none

`include "softex_defs.svh"

package softex_pkg;

    typedef enum logic [2:0] {
        IDLE,
        ACCUMULATION,
        WAIT_DATAPATH_EMPTY,
        WAIT_ACCUMULATION,
        WAIT_INVERSION,
        DIVIDING,
        FINISHED
    } ctrl_state_e;

    // Same bit layout as the COMMANDS register
    typedef struct packed {
        logic [15:0] slot;
        logic [11:0] rsvd;
        logic        acquire;
        logic        last;
        logic        div_only;
        logic        acc_only;
    } cmd_t;

    typedef struct packed {
        logic                    valid;
        logic [`SOFTEX_FP_W-1:0] maximum;
        logic [`SOFTEX_FP_W-1:0] denominator;
    } slot_entry_t;

endpackage

`default_nettype wire

// File: hw/softex_cfg_if.sv
// Programmed job as seen by the controller and the stream address generators
`timescale 1ns/10ps
`default_nettype none

interface softex_cfg_if;

    logic               start;  // One cycle pulse
    logic [31:0]        in_addr;
    logic [31:0]        out_addr;
    logic [31:0]        tot_len;
    softex_pkg::cmd_t   cmd;
    logic               busy;
    logic               done;

    modport regs (output start, in_addr, out_addr, tot_len, cmd, input busy, done);
    modport ctrl (input start, cmd, output busy, done);
    modport addr (input tot_len);

endinterface

`default_nettype wire

// File: hw/softex_axil_regs.sv
// AXI4-Lite slave with the job registers; a CTRL write while idle raises the start pulse
`timescale 1ns/10ps
`default_nettype none

`include "softex_defs.svh"

module softex_axil_regs (
    input  wire logic        clk_i,
    input  wire logic        rst_ni,
    input  wire logic [11:0] awaddr_i,
    input  wire logic        awvalid_i,
    output logic             awready_o,
    input  wire logic [31:0] wdata_i,
    input  wire logic [3:0]  wstrb_i,
    input  wire logic        wvalid_i,
    output logic             wready_o,
    output logic [1:0]       bresp_o,
    output logic             bvalid_o,
    input  wire logic        bready_i,
    input  wire logic [11:0] araddr_i,
    input  wire logic        arvalid_i,
    output logic             arready_o,
    output logic [31:0]      rdata_o,
    output logic [1:0]       rresp_o,
    output logic             rvalid_o,
    input  wire logic        rready_i,
    softex_cfg_if.regs       cfg
);

    logic        aw_q, w_q, bvalid_q, rvalid_q, start_q, done_q;
    logic [11:0] awaddr_q, wr_addr;
    logic [31:0] wdata_q, wr_data, rdata_q, rd_data;
    logic [3:0]  wstrb_q, wr_strb;
    logic [31:0] in_addr_q, out_addr_q, tot_len_q, cmd_q;
    logic        wr_en;

    function automatic logic [31:0] merge(input logic [31:0] old, input logic [31:0] data,
                                          input logic [3:0] strb);
        logic [31:0] res;
        res = old;
        for (int b = 0; b < 4; b++) begin
            if (strb[b])
                res[8*b +: 8] = data[8*b +: 8];
        end
        return res;
    endfunction

    assign awready_o = !aw_q && !bvalid_q;
    assign wready_o  = !w_q && !bvalid_q;
    assign arready_o = !rvalid_q;

    // Either channel may already be parked in its holding register
    assign wr_addr = aw_q ? awaddr_q : awaddr_i;
    assign wr_data = w_q ? wdata_q : wdata_i;
    assign wr_strb = w_q ? wstrb_q : wstrb_i;
    assign wr_en   = (aw_q || (awvalid_i && awready_o)) && (w_q || (wvalid_i && wready_o));

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            {aw_q, w_q, bvalid_q, rvalid_q, start_q, done_q} <= '0;
            {in_addr_q, out_addr_q, tot_len_q, cmd_q} <= '0;
        end else begin
            start_q <= 1'b0;
            if (cfg.done)
                done_q <= 1'b1;
            else if (start_q)
                done_q <= 1'b0;
            if (bvalid_q && bready_i)
                bvalid_q <= 1'b0;
            if (rvalid_q && rready_i)
                rvalid_q <= 1'b0;
            else if (arvalid_i && arready_o)
                rvalid_q <= 1'b1;
            if (wr_en) begin
                aw_q     <= 1'b0;
                w_q      <= 1'b0;
                bvalid_q <= 1'b1;
                case (wr_addr)
                    `SOFTEX_REG_CTRL:     start_q    <= wr_strb[0] && wr_data[0] && !cfg.busy;
                    `SOFTEX_REG_IN_ADDR:  in_addr_q  <= merge(in_addr_q, wr_data, wr_strb);
                    `SOFTEX_REG_OUT_ADDR: out_addr_q <= merge(out_addr_q, wr_data, wr_strb);
                    `SOFTEX_REG_TOT_LEN:  tot_len_q  <= merge(tot_len_q, wr_data, wr_strb);
                    `SOFTEX_REG_COMMANDS: cmd_q      <= merge(cmd_q, wr_data, wr_strb);
                    default: ;
                endcase
            end else begin
                if (awvalid_i && awready_o)
                    aw_q <= 1'b1;
                if (wvalid_i && wready_o)
                    w_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (awvalid_i && awready_o)
            awaddr_q <= awaddr_i;
        if (wvalid_i && wready_o) begin
            wdata_q <= wdata_i;
            wstrb_q <= wstrb_i;
        end
        if (arvalid_i && arready_o)
            rdata_q <= rd_data;
    end

    always_comb begin
        case (araddr_i)
            `SOFTEX_REG_STATUS:   rd_data = {30'd0, done_q, cfg.busy};
            `SOFTEX_REG_IN_ADDR:  rd_data = in_addr_q;
            `SOFTEX_REG_OUT_ADDR: rd_data = out_addr_q;
            `SOFTEX_REG_TOT_LEN:  rd_data = tot_len_q;
            `SOFTEX_REG_COMMANDS: rd_data = cmd_q;
            default:              rd_data = '0;
        endcase
    end

    assign bvalid_o = bvalid_q;
    assign bresp_o  = 2'b00;
    assign rvalid_o = rvalid_q;
    assign rdata_o  = rdata_q;
    assign rresp_o  = 2'b00;

    assign cfg.start    = start_q;
    assign cfg.in_addr  = in_addr_q;
    assign cfg.out_addr = out_addr_q;
    assign cfg.tot_len  = tot_len_q;
    assign cfg.cmd      = '{slot: cmd_q[31:16], rsvd: '0,
                            acquire: cmd_q[`SOFTEX_CMD_ACQUIRE], last: cmd_q[`SOFTEX_CMD_LAST],
                            div_only: cmd_q[`SOFTEX_CMD_DIV_ONLY],
                            acc_only: cmd_q[`SOFTEX_CMD_ACC_ONLY]};

    a_aw_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
        awvalid_i && !awready_o |=> awvalid_i);

endmodule

`default_nettype wire

// File: hw/softex_ctrl_fsm.sv
// Sequences the softmax phases: accumulation, drain, final accumulation, inversion, division
`timescale 1ns/10ps
`default_nettype none

module softex_ctrl_fsm (
    input  wire logic  clk_i,
    input  wire logic  rst_ni,
    softex_cfg_if.ctrl cfg,
    output logic       in_start_o,
    output logic       out_start_o,
    input  wire logic  in_done_i,
    input  wire logic  out_done_i,
    input  wire logic  dp_busy_i,
    input  wire logic  dp_acc_done_i,
    input  wire logic  dp_inv_done_i,
    output logic       dp_acc_finished_o,
    output logic       dp_dividing_o,
    output logic       dp_load_max_o,
    output logic       dp_load_den_o,
    output logic       dp_load_recip_o,
    output logic       slot_we_o,
    output logic       slot_free_o
);

    import softex_pkg::*;

    ctrl_state_e state_q, state_d;
    logic        out_done_q;  // Output stream may finish before the reciprocal is ready

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q    <= IDLE;
            out_done_q <= 1'b0;
        end else begin
            state_q <= state_d;
            if (state_q == FINISHED)
                out_done_q <= 1'b0;
            else if (out_done_i)
                out_done_q <= 1'b1;
        end
    end

    always_comb begin
        state_d           = state_q;
        in_start_o        = 1'b0;
        out_start_o       = 1'b0;
        dp_acc_finished_o = 1'b0;
        dp_dividing_o     = 1'b0;
        dp_load_max_o     = 1'b0;
        dp_load_den_o     = 1'b0;
        dp_load_recip_o   = 1'b0;
        case (state_q)
            IDLE: begin
                if (cfg.start) begin
                    in_start_o = 1'b1;
                    if (cfg.cmd.div_only) begin
                        state_d     = DIVIDING;
                        out_start_o = 1'b1;
                    end else begin
                        state_d = ACCUMULATION;
                    end
                    // Resume a partial operation from its slot
                    if ((cfg.cmd.acc_only || cfg.cmd.div_only) && !cfg.cmd.acquire) begin
                        dp_load_max_o   = 1'b1;
                        dp_load_den_o   = cfg.cmd.acc_only;
                        dp_load_recip_o = !cfg.cmd.acc_only;
                    end
                end
            end
            ACCUMULATION: begin
                if (in_done_i)
                    state_d = WAIT_DATAPATH_EMPTY;
            end
            WAIT_DATAPATH_EMPTY: begin
                if (!dp_busy_i) begin
                    state_d           = WAIT_ACCUMULATION;
                    dp_acc_finished_o = 1'b1;
                end
            end
            WAIT_ACCUMULATION: begin
                dp_acc_finished_o = 1'b1;
                if (dp_acc_done_i) begin
                    if (cfg.cmd.acc_only && !cfg.cmd.last) begin
                        state_d = FINISHED;
                    end else begin
                        state_d = WAIT_INVERSION;
                        if (!cfg.cmd.acc_only) begin
                            dp_acc_finished_o = 1'b0;
                            in_start_o        = 1'b1;  // Second pass over the input
                            out_start_o       = 1'b1;
                        end
                    end
                end
            end
            WAIT_INVERSION: begin
                dp_dividing_o = 1'b1;
                if (dp_inv_done_i)
                    state_d = cfg.cmd.acc_only ? FINISHED : DIVIDING;
            end
            DIVIDING: begin
                dp_dividing_o = 1'b1;
                if (out_done_i || out_done_q)
                    state_d = FINISHED;
            end
            FINISHED: state_d = IDLE;
            default:  state_d = IDLE;
        endcase
    end

    assign cfg.busy    = (state_q != IDLE) && (state_q != FINISHED);
    assign cfg.done    = state_q == FINISHED;
    assign slot_we_o   = (state_q == FINISHED) && cfg.cmd.acc_only;
    assign slot_free_o = (state_q == FINISHED) && cfg.cmd.div_only && cfg.cmd.last;

    // The register block must hold back a second start until the job has left IDLE
    a_start_idle: assert property (@(posedge clk_i) disable iff (!rst_ni)
        cfg.start |-> state_q == IDLE);

endmodule

`default_nettype wire

// File: hw/softex_addr_gen.sv
// Stream address generator, one request per beat from the base address in beat-sized steps
`timescale 1ns/10ps
`default_nettype none

`include "softex_defs.svh"

module softex_addr_gen (
    input  wire logic        clk_i,
    input  wire logic        rst_ni,
    softex_cfg_if.addr       cfg,
    input  wire logic        start_i,
    input  wire logic [31:0] base_addr_i,
    output logic             req_o,
    output logic [31:0]      addr_o,
    input  wire logic        gnt_i,
    output logic             done_o
);

    localparam int unsigned SHIFT = $clog2(`SOFTEX_BEAT_BYTES);

    logic [32-SHIFT:0] n_beats, remain_q;
    logic              active_q, done_q;
    logic [31:0]       addr_q;

    // A partial last beat still costs a whole beat
    assign n_beats = {1'b0, cfg.tot_len[31:SHIFT]} + (cfg.tot_len[SHIFT-1:0] != '0);

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            active_q <= 1'b0;
            done_q   <= 1'b0;
            remain_q <= '0;
            addr_q   <= '0;
        end else begin
            done_q <= 1'b0;
            if (start_i) begin
                addr_q   <= base_addr_i;
                remain_q <= n_beats;
                active_q <= n_beats != '0;
                done_q   <= n_beats == '0;
            end else if (active_q && gnt_i) begin
                addr_q   <= addr_q + `SOFTEX_BEAT_BYTES;
                remain_q <= remain_q - 1'b1;
                if (remain_q == 1) begin
                    active_q <= 1'b0;
                    done_q   <= 1'b1;
                end
            end
        end
    end

    assign req_o  = active_q;
    assign addr_o = addr_q;
    assign done_o = done_q;

    a_addr_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
        req_o && !gnt_i |=> $stable(addr_o));

endmodule

`default_nettype wire

// File: hw/softex_slot_store.sv
// Local store of partial softmax state, one maximum and denominator per slot
`timescale 1ns/10ps
`default_nettype none

`include "softex_defs.svh"

module softex_slot_store (
    input  wire logic                                clk_i,
    input  wire logic                                rst_ni,
    input  wire logic [$clog2(`SOFTEX_N_SLOTS)-1:0]  idx_i,
    input  wire logic                                we_i,
    input  wire logic                                free_i,
    input  wire logic [`SOFTEX_FP_W-1:0]             max_i,
    input  wire logic [`SOFTEX_FP_W-1:0]             den_i,
    output softex_pkg::slot_entry_t                  entry_o
);

    logic [`SOFTEX_N_SLOTS-1:0] valid_q;
    logic [`SOFTEX_FP_W-1:0]    max_q [`SOFTEX_N_SLOTS];
    logic [`SOFTEX_FP_W-1:0]    den_q [`SOFTEX_N_SLOTS];

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni)
            valid_q <= '0;
        else if (we_i)
            valid_q[idx_i] <= 1'b1;
        else if (free_i)
            valid_q[idx_i] <= 1'b0;
    end

    always_ff @(posedge clk_i) begin
        if (we_i) begin
            max_q[idx_i] <= max_i;
            den_q[idx_i] <= den_i;
        end
    end

    assign entry_o = '{valid: valid_q[idx_i], maximum: max_q[idx_i], denominator: den_q[idx_i]};

endmodule

`default_nettype wire

// File: hw/softex_top.sv
// Top level of the softmax sequencing core; the arithmetic datapath connects on the dp_ ports
`timescale 1ns/10ps
`default_nettype none

`include "softex_defs.svh"

module softex_top (
    input  wire logic                    clk_i,
    input  wire logic                    rst_ni,
    input  wire logic [11:0]             awaddr_i,
    input  wire logic                    awvalid_i,
    output logic                         awready_o,
    input  wire logic [31:0]             wdata_i,
    input  wire logic [3:0]              wstrb_i,
    input  wire logic                    wvalid_i,
    output logic                         wready_o,
    output logic [1:0]                   bresp_o,
    output logic                         bvalid_o,
    input  wire logic                    bready_i,
    input  wire logic [11:0]             araddr_i,
    input  wire logic                    arvalid_i,
    output logic                         arready_o,
    output logic [31:0]                  rdata_o,
    output logic [1:0]                   rresp_o,
    output logic                         rvalid_o,
    input  wire logic                    rready_i,
    output logic                         in_req_o,
    output logic [31:0]                  in_addr_o,
    input  wire logic                    in_gnt_i,
    output logic                         out_req_o,
    output logic [31:0]                  out_addr_o,
    input  wire logic                    out_gnt_i,
    input  wire logic                    dp_busy_i,
    input  wire logic                    dp_acc_done_i,
    input  wire logic                    dp_inv_done_i,
    input  wire logic [`SOFTEX_FP_W-1:0] dp_max_i,
    input  wire logic [`SOFTEX_FP_W-1:0] dp_den_i,
    input  wire logic [`SOFTEX_FP_W-1:0] dp_recip_i,
    output logic                         dp_acc_finished_o,
    output logic                         dp_dividing_o,
    output logic                         dp_load_max_o,
    output logic                         dp_load_den_o,
    output logic                         dp_load_recip_o,
    output logic [`SOFTEX_FP_W-1:0]      dp_max_o,
    output logic [`SOFTEX_FP_W-1:0]      dp_den_o,
    output logic                         busy_o,
    output logic                         evt_o
);

    import softex_pkg::*;

    slot_entry_t slot_entry;
    logic        in_start, out_start, in_done, out_done, slot_we, slot_free;

    softex_cfg_if cfg_if ();

    softex_axil_regs u_regs (
        .clk_i, .rst_ni,
        .awaddr_i, .awvalid_i, .awready_o,
        .wdata_i, .wstrb_i, .wvalid_i, .wready_o,
        .bresp_o, .bvalid_o, .bready_i,
        .araddr_i, .arvalid_i, .arready_o,
        .rdata_o, .rresp_o, .rvalid_o, .rready_i,
        .cfg (cfg_if.regs)
    );

    softex_ctrl_fsm u_ctrl (
        .clk_i, .rst_ni,
        .cfg         (cfg_if.ctrl),
        .in_start_o  (in_start),
        .out_start_o (out_start),
        .in_done_i   (in_done),
        .out_done_i  (out_done),
        .dp_busy_i, .dp_acc_done_i, .dp_inv_done_i,
        .dp_acc_finished_o, .dp_dividing_o,
        .dp_load_max_o, .dp_load_den_o, .dp_load_recip_o,
        .slot_we_o   (slot_we),
        .slot_free_o (slot_free)
    );

    softex_addr_gen u_in_gen (
        .clk_i, .rst_ni,
        .cfg         (cfg_if.addr),
        .start_i     (in_start),
        .base_addr_i (cfg_if.in_addr),
        .req_o       (in_req_o),
        .addr_o      (in_addr_o),
        .gnt_i       (in_gnt_i),
        .done_o      (in_done)
    );

    softex_addr_gen u_out_gen (
        .clk_i, .rst_ni,
        .cfg         (cfg_if.addr),
        .start_i     (out_start),
        .base_addr_i (cfg_if.out_addr),
        .req_o       (out_req_o),
        .addr_o      (out_addr_o),
        .gnt_i       (out_gnt_i),
        .done_o      (out_done)
    );

    // A partial accumulation keeps the raw denominator, a finished one keeps the reciprocal
    softex_slot_store u_slot (
        .clk_i, .rst_ni,
        .idx_i   (cfg_if.cmd.slot[$clog2(`SOFTEX_N_SLOTS)-1:0]),
        .we_i    (slot_we),
        .free_i  (slot_free),
        .max_i   (dp_max_i),
        .den_i   ((cfg_if.cmd.acc_only && !cfg_if.cmd.last) ? dp_den_i : dp_recip_i),
        .entry_o (slot_entry)
    );

    assign dp_max_o = slot_entry.maximum;
    assign dp_den_o = slot_entry.denominator;
    assign busy_o   = cfg_if.busy;
    assign evt_o    = cfg_if.done;

    // A resumed job must name a slot that holds saved state
    a_load_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
        dp_load_max_o |-> slot_entry.valid);

endmodule

`default_nettype wire

// File: tb/tb_softex.sv
// Directed testbench of the softmax sequencing core with a cycle-based datapath model
// Drives AXI4-Lite jobs into softex_top and checks stream addresses, slot loads and events
`timescale 1ns/10ps
`default_nettype none

`include "softex_defs.svh"

module tb_softex;

    localparam int unsigned AXI_TIMEOUT = 50;
    localparam int unsigned JOB_TIMEOUT = 2000;
    localparam int unsigned TAIL_CYCLES = 20;  // Quiet cycles watched after the event

    logic        clk_i, rst_ni;
    logic [11:0] awaddr_i, araddr_i;
    logic        awvalid_i, awready_o, wvalid_i, wready_o, bvalid_o, bready_i;
    logic [31:0] wdata_i, rdata_o;
    logic [3:0]  wstrb_i;
    logic [1:0]  bresp_o, rresp_o;
    logic        arvalid_i, arready_o, rvalid_o, rready_i;
    logic        in_req_o, in_gnt_i, out_req_o, out_gnt_i;
    logic [31:0] in_addr_o, out_addr_o;
    logic        dp_busy_i, dp_acc_done_i, dp_inv_done_i;
    logic [31:0] dp_max_i, dp_den_i, dp_recip_i, dp_max_o, dp_den_o;
    logic        dp_acc_finished_o, dp_dividing_o, dp_load_max_o, dp_load_den_o;
    logic        dp_load_recip_o, busy_o, evt_o;

    int unsigned errors, checks, evt_cnt, load_cnt;
    logic [31:0] lfsr_state, load_max_val, load_den_val;
    logic [31:0] in_beats[$], out_beats[$];
    logic        load_den, load_recip;

    softex_top UUT (.*);

    always #2 clk_i = ~clk_i;

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] rand_bits(input int unsigned n);
        logic [31:0] r;
        r = '0;
        for (int unsigned i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            r = {r[30:0], lfsr_state[31]};
        end
        return r;
    endfunction

    function automatic int unsigned beat_count(input int unsigned len);
        return (len + `SOFTEX_BEAT_BYTES - 1) / `SOFTEX_BEAT_BYTES;
    endfunction

    task automatic check_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t: %s = 0x%08h, expected 0x%08h", $time, what, got, exp);
        end
    endtask

    // All bus tasks start and end 0.5 ns after a rising edge and sample on the falling edge
    task automatic axil_write(input logic [11:0] addr, input logic [31:0] data);
        int unsigned t;
        bit          aw_done, w_done, b_done;
        {aw_done, w_done, b_done} = '0;
        awaddr_i  = addr;
        wdata_i   = data;
        wstrb_i   = 4'hf;
        awvalid_i = 1'b1;
        wvalid_i  = 1'b1;
        bready_i  = 1'b1;
        t = 0;
        while (!b_done && t < AXI_TIMEOUT) begin
            @(negedge clk_i);
            if (awvalid_i && awready_o) aw_done = 1'b1;
            if (wvalid_i && wready_o) w_done = 1'b1;
            if (bvalid_o) begin
                b_done = 1'b1;
                check_eq("bresp_o", bresp_o, 2'b00);
            end
            @(posedge clk_i);
            #0.5;
            if (aw_done) awvalid_i = 1'b0;
            if (w_done) wvalid_i = 1'b0;
            t++;
        end
        bready_i = 1'b0;
        if (!b_done) begin
            errors++;
            $display("Error at %0t: write to 0x%03h got no response", $time, addr);
        end
    endtask

    task automatic axil_read(input logic [11:0] addr, output logic [31:0] data);
        int unsigned t;
        bit          ar_done, r_done;
        {ar_done, r_done} = '0;
        data      = 'x;
        araddr_i  = addr;
        arvalid_i = 1'b1;
        rready_i  = 1'b1;
        t = 0;
        while (!r_done && t < AXI_TIMEOUT) begin
            @(negedge clk_i);
            if (arvalid_i && arready_o) ar_done = 1'b1;
            if (rvalid_o) begin
                r_done = 1'b1;
                data   = rdata_o;
                check_eq("rresp_o", rresp_o, 2'b00);
            end
            @(posedge clk_i);
            #0.5;
            if (ar_done) arvalid_i = 1'b0;
            t++;
        end
        rready_i = 1'b0;
        if (!r_done) begin
            errors++;
            $display("Error at %0t: read of 0x%03h got no data", $time, addr);
        end
    endtask

    task automatic program_job(input logic [31:0] in_base, input logic [31:0] out_base,
                               input logic [31:0] len, input logic [31:0] cmd);
        axil_write(`SOFTEX_REG_IN_ADDR, in_base);
        axil_write(`SOFTEX_REG_OUT_ADDR, out_base);
        axil_write(`SOFTEX_REG_TOT_LEN, len);
        axil_write(`SOFTEX_REG_COMMANDS, cmd);
    endtask

    // Plays the datapath and the memory side until the event plus a quiet tail
    task automatic run_job(input bit stall, input bit out_needs_acc);
        int unsigned cyc, tail, busy_cnt, acc_wait, inv_wait;
        bit          acc_armed, acc_fired, inv_armed, inv_fired, finished, order_err;
        in_beats.delete();
        out_beats.delete();
        {evt_cnt, load_cnt, cyc, tail, busy_cnt, acc_wait, inv_wait} = '0;
        {acc_armed, acc_fired, inv_armed, inv_fired, finished, order_err} = '0;
        while (tail < TAIL_CYCLES && cyc < JOB_TIMEOUT) begin
            @(negedge clk_i);
            if (in_req_o && in_gnt_i) begin
                in_beats.push_back(in_addr_o);
                busy_cnt = 2 + rand_bits(2);  // Pipeline drain after each beat
            end
            if (out_req_o && out_gnt_i)
                out_beats.push_back(out_addr_o);
            if (out_req_o && out_needs_acc && !acc_fired && !order_err) begin
                order_err = 1'b1;
                errors++;
                $display("Error at %0t: output stream started before dp_acc_done_i", $time);
            end
            if (evt_o) begin
                evt_cnt++;
                finished = 1'b1;
                check_eq("busy_o", busy_o, 1'b0);
            end
            if (dp_load_max_o) begin
                load_cnt++;
                load_den     = dp_load_den_o;
                load_recip   = dp_load_recip_o;
                load_max_val = dp_max_o;
                load_den_val = dp_den_o;
            end
            if (dp_acc_finished_o && !acc_armed) begin
                acc_armed = 1'b1;
                acc_wait  = rand_bits(3);
            end
            if (acc_fired && dp_dividing_o && !inv_armed) begin
                inv_armed = 1'b1;
                inv_wait  = rand_bits(3);
            end
            @(posedge clk_i);
            #0.5;
            in_gnt_i      = stall ? (rand_bits(1) != 0) : 1'b1;
            out_gnt_i     = stall ? (rand_bits(1) != 0) : 1'b1;
            dp_busy_i     = busy_cnt != 0;
            dp_acc_done_i = 1'b0;
            dp_inv_done_i = 1'b0;
            if (busy_cnt != 0) busy_cnt--;
            if (acc_armed && !acc_fired) begin
                if (acc_wait == 0) begin
                    dp_acc_done_i = 1'b1;
                    acc_fired     = 1'b1;
                end else acc_wait--;
            end
            if (inv_armed && !inv_fired) begin
                if (inv_wait == 0) begin
                    dp_inv_done_i = 1'b1;
                    inv_fired     = 1'b1;
                end else inv_wait--;
            end
            cyc++;
            if (finished) tail++;
        end
        if (!finished) begin
            errors++;
            $display("Error at %0t: job never raised evt_o", $time);
        end
    endtask

    task automatic check_stream(input bit use_out, input logic [31:0] base,
                                input int unsigned len, input int unsigned passes);
        logic [31:0] q[$];
        int unsigned n;
        string       name;
        if (use_out) begin
            q    = out_beats;
            name = "out_addr_o";
        end else begin
            q    = in_beats;
            name = "in_addr_o";
        end
        n = beat_count(len);
        check_eq({name, " beat count"}, q.size(), n * passes);
        for (int unsigned i = 0; i < q.size() && i < n * passes; i++)
            check_eq(name, q[i], base + (i % n) * `SOFTEX_BEAT_BYTES);
    endtask

    task automatic wait_busy();
        int unsigned t;
        t = 0;
        while (!busy_o && t < AXI_TIMEOUT) begin
            @(posedge clk_i);
            #0.5;
            t++;
        end
        if (!busy_o) begin
            errors++;
            $display("Error at %0t: busy_o never rose after the start", $time);
        end
    endtask

    task automatic regs_readback();
        logic [31:0] d;
        axil_read(`SOFTEX_REG_STATUS, d);
        check_eq("STATUS", d, 32'h0);
        program_job(32'h1000_0040, 32'h2000_0080, 32'd100, 32'h0002_0009);
        axil_read(`SOFTEX_REG_IN_ADDR, d);
        check_eq("IN_ADDR", d, 32'h1000_0040);
        axil_read(`SOFTEX_REG_OUT_ADDR, d);
        check_eq("OUT_ADDR", d, 32'h2000_0080);
        axil_read(`SOFTEX_REG_TOT_LEN, d);
        check_eq("TOT_LEN", d, 32'd100);
        axil_read(`SOFTEX_REG_COMMANDS, d);
        check_eq("COMMANDS", d, 32'h0002_0009);
        axil_read(12'h100, d);  // Hole in the map
        check_eq("unmapped read", d, 32'h0);
    endtask

    task automatic full_softmax(input int unsigned len, input logic [31:0] in_base,
                                input logic [31:0] out_base, input bit stall);
        logic [31:0] d;
        program_job(in_base, out_base, len, 32'h0);
        fork
            axil_write(`SOFTEX_REG_CTRL, 32'h1);
            run_job(stall, 1'b1);
        join
        check_stream(1'b0, in_base, len, 2);  // Accumulation pass, then the division pass
        check_stream(1'b1, out_base, len, 1);
        check_eq("evt_o pulses", evt_cnt, 1);
        check_eq("dp_load_max_o pulses", load_cnt, 0);
        axil_read(`SOFTEX_REG_STATUS, d);
        check_eq("STATUS", d, 32'h2);
    endtask

    task automatic slot_resume();
        logic [31:0] max_saved, den_saved;
        max_saved  = 32'h4049_0fdb;
        den_saved  = 32'h4120_0000;
        dp_max_i   = max_saved;
        dp_den_i   = den_saved;
        dp_recip_i = 32'h3dcc_cccd;
        program_job(32'h3000_0000, 32'h4000_0000, 32'd48, {16'd2, 12'd0, 4'b1001});
        fork
            axil_write(`SOFTEX_REG_CTRL, 32'h1);
            run_job(1'b0, 1'b0);
        join
        check_stream(1'b0, 32'h3000_0000, 48, 1);
        check_eq("out_req_o beats", out_beats.size(), 0);
        check_eq("dp_load_max_o pulses", load_cnt, 0);
        check_eq("evt_o pulses", evt_cnt, 1);
        // New datapath values must not reach the slot any more
        dp_max_i   = 32'h1111_2222;
        dp_den_i   = 32'h3333_4444;
        dp_recip_i = 32'h5555_6666;
        axil_write(`SOFTEX_REG_COMMANDS, {16'd2, 12'd0, 4'b0110});
        fork
            axil_write(`SOFTEX_REG_CTRL, 32'h1);
            run_job(1'b0, 1'b0);
        join
        check_eq("dp_load_max_o pulses", load_cnt, 1);
        check_eq("dp_load_recip_o", load_recip, 1'b1);
        check_eq("dp_load_den_o", load_den, 1'b0);
        check_eq("dp_max_o", load_max_val, max_saved);
        check_eq("dp_den_o", load_den_val, den_saved);
        check_stream(1'b0, 32'h3000_0000, 48, 1);
        check_stream(1'b1, 32'h4000_0000, 48, 1);
        check_eq("evt_o pulses", evt_cnt, 1);
    endtask

    task automatic busy_ctrl_write();
        program_job(32'h5000_0100, 32'h6000_0200, 32'd48, 32'h0);
        fork
            begin
                axil_write(`SOFTEX_REG_CTRL, 32'h1);
                wait_busy();
                axil_write(`SOFTEX_REG_CTRL, 32'h1);
                check_eq("busy_o", busy_o, 1'b1);  // Second write landed inside the job
            end
            run_job(1'b0, 1'b1);
        join
        check_eq("evt_o pulses", evt_cnt, 1);
        check_stream(1'b0, 32'h5000_0100, 48, 2);
        check_stream(1'b1, 32'h6000_0200, 48, 1);
    endtask

    initial begin
        {clk_i, rst_ni} = 2'b00;
        {awaddr_i, araddr_i, wdata_i, wstrb_i} = '0;
        {awvalid_i, wvalid_i, bready_i, arvalid_i, rready_i} = '0;
        {in_gnt_i, out_gnt_i, dp_busy_i, dp_acc_done_i, dp_inv_done_i} = '0;
        {dp_max_i, dp_den_i, dp_recip_i} = '0;
        {errors, checks} = '0;
        lfsr_state = 32'hce04_9041;
        repeat (8) @(posedge clk_i);
        #0.5;
        rst_ni = 1'b1;
        check_eq("req/evt/busy/dp control outputs",
                 {in_req_o, out_req_o, evt_o, busy_o, dp_acc_finished_o, dp_dividing_o,
                  dp_load_max_o, dp_load_den_o, dp_load_recip_o}, 32'h0);
        regs_readback();
        full_softmax(100, 32'h1000_0000, 32'h2000_0000, 1'b0);
        full_softmax(64, 32'h1000_0400, 32'h2000_0800, 1'b1);
        slot_resume();
        busy_ctrl_write();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

// File: flist.f
+incdir+hw
hw/softex_pkg.sv
hw/softex_cfg_if.sv
hw/softex_axil_regs.sv
hw/softex_ctrl_fsm.sv
hw/softex_addr_gen.sv
hw/softex_slot_store.sv
hw/softex_top.sv
tb/tb_softex.sv

// File: Makefile
# Verilator build and run of the softmax sequencing core testbench

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, fail on a failing run"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -Wno-fatal -f flist.f --top-module tb_softex
	-./obj_dir/Vtb_softex > sim.log 2>&1
	@cat sim.log
	@if grep -q '\*\*\* FAILED \*\*\*' sim.log || ! grep -q 'PASSED' sim.log; then \
		echo "Simulation failed"; exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log
